/* project.f */
hw/arduboy_pkg.sv
hw/display_if.sv
hw/rom_loader.sv
hw/program_rom.sv
hw/video_cleanup.sv
hw/i2s_mclk_gen.sv
hw/i2s_serializer.sv
hw/arduboy_shell.sv
testbench/arduboy_shell_properties.sv
testbench/tb_arduboy_shell.sv

/* Makefile */
# verilator build for the arduboy shell testbench

TOP := tb_arduboy_shell

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_arduboy_shell.sv */
/*
 * testbench for the arduboy shell: rom load and fetch, button map,
 * video sync, enable and rgb, mclk timing and i2s frames
 * inputs change on the falling clock edge, outputs are sampled there too
 */

`default_nettype none

module tb_arduboy_shell;

  import arduboy_pkg::*;

  localparam int MCLK_WAIT_MAX  = 16;
  localparam int LRCK_WAIT_MAX  = 600;

  logic         clk_74a = 1'b0;
  logic         rst;
  bridge_word_t bridge_addr;
  logic         bridge_wr;
  bridge_word_t bridge_wr_data;
  logic [15:0]  cont1_key;
  rom_addr_t    pgm_addr;
  rom_word_t    pgm_data;
  logic [BUTTON_COUNT-1:0] buttons;
  logic         buzzer1;
  logic         buzzer2;
  logic         disp_hsync;
  logic         disp_vsync;
  logic         disp_hblank;
  logic         disp_vblank;
  logic         disp_pixel;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  logic         video_skip;
  logic         audio_mclk;
  logic         audio_dac;
  logic         audio_lrck;

  // bookkeeping
  logic [31:0]  lcg_state = 32'he80e;
  int           checks = 0;
  int           errors = 0;
  int           tests_run = 0;
  int           check_base;
  int           error_base;
  int           prop_fail;
  bit           timed_out = 1'b0;

  always #2 clk_74a = ~clk_74a;

  arduboy_shell arduboy_shell_inst (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .cont1_key      (cont1_key),
    .pgm_addr       (pgm_addr),
    .pgm_data       (pgm_data),
    .buttons        (buttons),
    .buzzer1        (buzzer1),
    .buzzer2        (buzzer2),
    .disp_hsync     (disp_hsync),
    .disp_vsync     (disp_vsync),
    .disp_hblank    (disp_hblank),
    .disp_vblank    (disp_vblank),
    .disp_pixel     (disp_pixel),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .video_skip     (video_skip),
    .audio_mclk     (audio_mclk),
    .audio_dac      (audio_dac),
    .audio_lrck     (audio_lrck)
  );

  ////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // top half of the two-buzzer sum, each word 30 ones under two zeros
  function automatic logic [15:0] mix_top(input logic b1, input logic b2);
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] sum;
    w1  = b1 ? 32'h3fff_ffff : 32'h0;
    w2  = b2 ? 32'h3fff_ffff : 32'h0;
    sum = w1 + w2;
    return sum[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    assert (got == expected)
    else
    begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic begin_test();
    check_base = checks;
    error_base = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("%s: %0d checks, %0d errors", name, checks - check_base, errors - error_base);
  endtask

  // one bridge beat, then two idle cycles
  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    repeat (2) @(negedge clk_74a);
  endtask

  task automatic fetch_check(input rom_addr_t addr, input rom_word_t expected);
    pgm_addr = addr;
    @(negedge clk_74a);
    check_value("pgm_data", 32'(pgm_data), 32'(expected));
  endtask

  // len counts clocks until audio_mclk changes level
  task automatic wait_mclk_edge(output int len);
    logic prev;
    bit   seen;
    len = 0;
    if (timed_out)
    begin
      return;
    end
    prev = audio_mclk;
    seen = 1'b0;
    while (!seen && len < MCLK_WAIT_MAX)
    begin
      @(negedge clk_74a);
      len++;
      seen = (audio_mclk != prev);
    end
    if (!seen)
    begin
      timed_out = 1'b1;
      $display("Timeout: audio_mclk stopped toggling");
    end
  endtask

  task automatic wait_mclk_rise();
    int len;
    wait_mclk_edge(len);
    if (!timed_out && !audio_mclk)
    begin
      wait_mclk_edge(len);
    end
  endtask

  // returns one mclk rise after lrck has dropped to the left channel
  task automatic align_left_start();
    logic prev;
    bit   found;
    int   n;
    prev  = audio_lrck;
    found = 1'b0;
    n     = 0;
    while (!found && !timed_out && n < LRCK_WAIT_MAX)
    begin
      wait_mclk_rise();
      n++;
      found = prev && !audio_lrck;
      prev  = audio_lrck;
    end
    if (!found && !timed_out)
    begin
      timed_out = 1'b1;
      $display("Timeout: audio_lrck never started a left slot");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // tests

  task automatic rom_load_test();
    bridge_word_t addr_list [12];
    bridge_word_t data;
    rom_word_t    model [int];
    rom_addr_t    word;
    int           i;
    for (i = 0; i < 12; i++)
    begin
      addr_list[i] = next_rand() & 32'h0000_7ffc;
      data         = next_rand();
      // big-endian, upper half at byte address over two
      word = rom_addr_t'(addr_list[i] >> 1);
      model[int'(word)]                   = data[31:16];
      model[int'(rom_addr_t'(word + 1))] = data[15:0];
      bridge_write(addr_list[i], data);
    end
    // same word bits but above the window, must be ignored
    bridge_write(ROM_WINDOW_BYTES + addr_list[0], next_rand());
    for (i = 0; i < 12; i++)
    begin
      word = rom_addr_t'(addr_list[i] >> 1);
      fetch_check(word, model[int'(word)]);
      fetch_check(rom_addr_t'(word + 1), model[int'(rom_addr_t'(word + 1))]);
    end
  endtask

  task automatic button_map_test();
    logic [31:0] r;
    logic [5:0]  expected;
    int          i;
    for (i = 0; i < 24; i++)
    begin
      @(negedge clk_74a);
      r         = next_rand();
      cont1_key = r[27:12];
      // key bits 0 up, 1 down, 2 left, 3 right, 4 a, 5 b
      expected[0] = ~cont1_key[3];
      expected[1] = ~cont1_key[2];
      expected[2] = ~cont1_key[1];
      expected[3] = ~cont1_key[0];
      expected[4] = ~cont1_key[4];
      expected[5] = ~cont1_key[5];
      #1;
      check_value("buttons", 32'(buttons), 32'(expected));
    end
  endtask

  // pulse lands 4 clocks after the rising input, one clock wide
  task automatic sync_pulse_test(input bit vertical);
    int k;
    if (vertical)
    begin
      disp_vsync = 1'b1;
    end
    else
    begin
      disp_hsync = 1'b1;
    end
    for (k = 1; k <= 11; k++)
    begin
      @(negedge clk_74a);
      if (vertical)
      begin
        check_value("video_vs", 32'(video_vs), 32'(k == 4));
      end
      else
      begin
        check_value("video_hs", 32'(video_hs), 32'(k == 4));
      end
      if (k == 6)
      begin
        disp_hsync = 1'b0;
        disp_vsync = 1'b0;
      end
    end
  endtask

  task automatic video_enable_test();
    logic [2:0]  hist [$];
    logic [2:0]  past;
    logic [31:0] r;
    logic        de_exp;
    rgb_t        rgb_exp;
    int          i;
    // inputs held long enough, pipeline holds the current values
    for (i = 0; i < 4; i++)
    begin
      hist.push_back({disp_hblank, disp_vblank, disp_pixel});
    end
    for (i = 0; i < 96; i++)
    begin
      @(negedge clk_74a);
      past    = hist.pop_front();
      de_exp  = ~(past[2] | past[1]);
      rgb_exp = (de_exp && past[0]) ? 24'hffffff : 24'h000000;
      check_value("video_de", 32'(video_de), 32'(de_exp));
      check_value("video_rgb", 32'(video_rgb), 32'(rgb_exp));
      // no frame is ever skipped
      check_value("video_skip", 32'(video_skip), 32'(0));
      r           = next_rand();
      disp_hblank = r[20] & r[21];
      disp_vblank = r[22] & r[23] & r[24];
      disp_pixel  = r[25];
      hist.push_back({disp_hblank, disp_vblank, disp_pixel});
    end
    disp_hblank = 1'b0;
    disp_vblank = 1'b0;
    disp_pixel  = 1'b0;
  endtask

  task automatic mclk_period_test();
    int len;
    int n;
    // first level is partial
    wait_mclk_edge(len);
    for (n = 0; n < 24 && !timed_out; n++)
    begin
      wait_mclk_edge(len);
      if (!timed_out)
      begin
        checks++;
        assert (len == 3 || len == 4)
        else
        begin
          errors++;
          $display("Fail audio_mclk half period: got %h clocks, expected 3 or 4", len);
        end
      end
    end
  endtask

  // one data bit every 4 mclk rises, msb one bit after the lrck change
  task automatic i2s_frame_test(input logic b1, input logic b2);
    logic [15:0] expected;
    logic        exp_dac;
    logic        exp_lrck;
    int          slot;
    int          k;
    buzzer1  = b1;
    buzzer2  = b2;
    expected = mix_top(b1, b2);
    // the second left start is loaded from the held levels
    align_left_start();
    align_left_start();
    for (slot = 0; slot < 4 && !timed_out; slot++)
    begin
      for (k = 1; k <= 32 && !timed_out; k++)
      begin
        repeat (4) wait_mclk_rise();
        if (!timed_out)
        begin
          exp_dac  = (k <= 16) ? expected[16 - k] : 1'b0;
          exp_lrck = (k == 32) ? ~slot[0] : slot[0];
          check_value("audio_dac", 32'(audio_dac), 32'(exp_dac));
          check_value("audio_lrck", 32'(audio_lrck), 32'(exp_lrck));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // sequence

  initial
  begin
    rst            = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    cont1_key      = '0;
    pgm_addr       = '0;
    buzzer1        = 1'b0;
    buzzer2        = 1'b0;
    disp_hsync     = 1'b0;
    disp_vsync     = 1'b0;
    disp_hblank    = 1'b0;
    disp_vblank    = 1'b0;
    disp_pixel     = 1'b0;
    repeat (5) @(negedge clk_74a);
    rst = 1'b0;
    @(negedge clk_74a);

    begin_test();
    rom_load_test();
    end_test("rom_load");

    begin_test();
    button_map_test();
    end_test("button_map");

    begin_test();
    repeat (3)
    begin
      sync_pulse_test(1'b0);
      sync_pulse_test(1'b1);
    end
    end_test("sync_pulses");

    begin_test();
    video_enable_test();
    end_test("video_enable_rgb");

    begin_test();
    mclk_period_test();
    end_test("mclk_period");

    begin_test();
    i2s_frame_test(1'b1, 1'b1);
    end_test("i2s_both_buzzers");

    begin_test();
    i2s_frame_test(1'b1, 1'b0);
    end_test("i2s_one_buzzer");

    prop_fail = arduboy_shell_inst.arduboy_shell_props_inst.prop_failures;
    $display("summary: %0d tests, %0d checks, %0d errors, %0d property failures",
             tests_run, checks, errors, prop_fail);
    if (errors == 0 && prop_fail == 0 && !timed_out)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/arduboy_shell_properties.sv */
/*
 * concurrent checks bound into arduboy_shell: sync pulse width, dark rgb
 * outside the enable, mclk half periods and bridge write spacing
 * failures also bump a counter that the testbench reads at the end
 */

`default_nettype none

module arduboy_shell_properties (
  input wire                            clk_74a,
  input wire                            rst,
  input wire arduboy_pkg::bridge_word_t bridge_addr,
  input wire                            bridge_wr,
  input wire arduboy_pkg::rgb_t         video_rgb,
  input wire                            video_de,
  input wire                            video_hs,
  input wire                            video_vs,
  input wire                            audio_mclk
);

  import arduboy_pkg::*;

  int prop_failures;

  // mclk level tracker
  logic       mclk_q;
  logic [3:0] half_len;
  logic       toggled_once;
  logic       mclk_toggle;

  initial
  begin
    prop_failures = 0;
  end

  assign mclk_toggle = audio_mclk != mclk_q;

  // half_len holds the length of the level that just ended
  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      mclk_q       <= 1'b0;
      half_len     <= '0;
      toggled_once <= 1'b0;
    end
    else
    begin
      mclk_q <= audio_mclk;
      if (mclk_toggle)
      begin
        half_len     <= 4'd1;
        toggled_once <= 1'b1;
      end
      else if (half_len != 4'hf)
      begin
        half_len <= half_len + 4'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // video

  hs_single_cycle: assert property (@(posedge clk_74a) disable iff (rst)
    video_hs |=> !video_hs)
  else
  begin
    $error("video_hs held high longer than one cycle");
    prop_failures++;
  end

  vs_single_cycle: assert property (@(posedge clk_74a) disable iff (rst)
    video_vs |=> !video_vs)
  else
  begin
    $error("video_vs held high longer than one cycle");
    prop_failures++;
  end

  rgb_dark_outside_de: assert property (@(posedge clk_74a) disable iff (rst)
    !video_de |-> (video_rgb == '0))
  else
  begin
    $error("video_rgb nonzero while video_de is low");
    prop_failures++;
  end

  //////////////////////////////////////////////////////////////////////
  // audio and loader

  // first level after reset is longer, skipped
  mclk_half_period: assert property (@(posedge clk_74a) disable iff (rst)
    (toggled_once && mclk_toggle) |-> (half_len == 4'd3 || half_len == 4'd4))
  else
  begin
    $error("audio_mclk half period outside 3 to 4 clocks");
    prop_failures++;
  end

  // a strobe in load_low_half would be dropped
  bridge_write_spacing: assert property (@(posedge clk_74a) disable iff (rst)
    (bridge_wr && bridge_addr < ROM_WINDOW_BYTES) |=> !bridge_wr)
  else
  begin
    $error("bridge write arrived while the loader was busy");
    prop_failures++;
  end

endmodule

bind arduboy_shell arduboy_shell_properties arduboy_shell_props_inst (
  .clk_74a     (clk_74a),
  .rst         (rst),
  .bridge_addr (bridge_addr),
  .bridge_wr   (bridge_wr),
  .video_rgb   (video_rgb),
  .video_de    (video_de),
  .video_hs    (video_hs),
  .video_vs    (video_vs),
  .audio_mclk  (audio_mclk)
);

`default_nettype wire

/* hw/arduboy_shell.sv */
/*
 * shell around the handheld core: rom load and fetch, button mapping,
 * display cleanup for the scaler and i2s audio from the buzzers
 * all logic runs on clk_74a; the core connects through plain ports
 */

`default_nettype none

module arduboy_shell #(
  parameter int          SYNC_STAGES  = 3,
  parameter logic [21:0] MCLK_STEP    = arduboy_pkg::MCLK_STEP,
  parameter logic [21:0] MCLK_MODULUS = arduboy_pkg::MCLK_MODULUS
) (
  input  wire                             clk_74a,
  input  wire                             rst,

  // bridge, write only
  input  wire arduboy_pkg::bridge_word_t  bridge_addr,
  input  wire                             bridge_wr,
  input  wire arduboy_pkg::bridge_word_t  bridge_wr_data,

  // controller 1 key bitmap
  input  wire logic [15:0]                cont1_key,

  // core program fetch
  input  wire arduboy_pkg::rom_addr_t     pgm_addr,
  output arduboy_pkg::rom_word_t          pgm_data,

  // core buttons, active low
  output logic [arduboy_pkg::BUTTON_COUNT-1:0] buttons,

  // core buzzers
  input  wire                             buzzer1,
  input  wire                             buzzer2,

  // core display timing
  input  wire                             disp_hsync,
  input  wire                             disp_vsync,
  input  wire                             disp_hblank,
  input  wire                             disp_vblank,
  input  wire                             disp_pixel,

  // scaler video
  output arduboy_pkg::rgb_t               video_rgb,
  output logic                            video_de,
  output logic                            video_hs,
  output logic                            video_vs,
  output logic                            video_skip,

  // i2s audio
  output logic                            audio_mclk,
  output logic                            audio_dac,
  output logic                            audio_lrck
);

  import arduboy_pkg::*;

  logic      rom_wr_en;
  rom_addr_t rom_wr_addr;
  rom_word_t rom_wr_data;
  logic      mclk_rise;

  display_if disp_bus ();

  ////////////////////////////////////////////////////////////////////
  // program rom

  rom_loader rom_loader_inst (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .rom_wr_en      (rom_wr_en),
    .rom_wr_addr    (rom_wr_addr),
    .rom_wr_data    (rom_wr_data)
  );

  program_rom program_rom_inst (
    .clk_74a     (clk_74a),
    .rom_wr_en   (rom_wr_en),
    .rom_wr_addr (rom_wr_addr),
    .rom_wr_data (rom_wr_data),
    .pgm_addr    (pgm_addr),
    .pgm_data    (pgm_data)
  );

  ////////////////////////////////////////////////////////////////////
  // buttons
  // key bits: 0 up, 1 down, 2 left, 3 right, 4 a, 5 b
  // core order: right, left, down, up, a, b

  assign buttons = ~{cont1_key[5], cont1_key[4], cont1_key[0],
                     cont1_key[1], cont1_key[2], cont1_key[3]};

  ////////////////////////////////////////////////////////////////////
  // video

  assign disp_bus.hsync  = disp_hsync;
  assign disp_bus.vsync  = disp_vsync;
  assign disp_bus.hblank = disp_hblank;
  assign disp_bus.vblank = disp_vblank;
  assign disp_bus.pixel  = disp_pixel;

  video_cleanup #(
    .SYNC_STAGES (SYNC_STAGES)
  ) video_cleanup_inst (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .disp      (disp_bus),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

  // every frame is shown
  assign video_skip = 1'b0;

  ////////////////////////////////////////////////////////////////////
  // audio

  i2s_mclk_gen #(
    .MCLK_STEP    (MCLK_STEP),
    .MCLK_MODULUS (MCLK_MODULUS)
  ) i2s_mclk_gen_inst (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .audio_mclk (audio_mclk),
    .mclk_rise  (mclk_rise)
  );

  i2s_serializer i2s_serializer_inst (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .mclk_rise  (mclk_rise),
    .buzzer1    (buzzer1),
    .buzzer2    (buzzer2),
    .audio_dac  (audio_dac),
    .audio_lrck (audio_lrck)
  );

endmodule

`default_nettype wire

/* hw/i2s_serializer.sv */
/*
 * mixes the two buzzer levels and shifts i2s frames out, 32-bit slots
 * with 16 active bits msb first; bit clock is mclk over four
 */

`default_nettype none

module i2s_serializer (
  input  wire  clk_74a,
  input  wire  rst,
  input  wire  mclk_rise,
  input  wire  buzzer1,
  input  wire  buzzer2,
  output logic audio_dac,
  output logic audio_lrck
);

  import arduboy_pkg::*;

  localparam int CNT_W = $clog2(SAMPLE_W);
  localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(SAMPLE_W - 1);

  logic [1:0]             bclk_div;
  logic                   bclk_fall;
  logic [CNT_W-1:0]       slot_cnt;
  i2s_channel_e           channel;
  logic [SAMPLE_W-1:0]    mix;
  logic [ACTIVE_BITS-1:0] sample_hi;
  logic [SAMPLE_W-1:0]    shifter;

  // top bit clear for sign, next bit clear for the carry of the add
  assign mix = {2'b00, {(SAMPLE_W-2){buzzer1}}} + {2'b00, {(SAMPLE_W-2){buzzer2}}};

  ////////////////////////////////////////////////////////////////////
  // bit clock, bclk_div[1] toggles every second mclk rise

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      bclk_div <= '0;
    end
    else if (mclk_rise)
    begin
      bclk_div <= bclk_div + 1'b1;
    end
  end

  // falling bit clock edge
  assign bclk_fall = mclk_rise && (bclk_div == 2'b11);

  ////////////////////////////////////////////////////////////////////
  // slot counter and shifter

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      slot_cnt  <= '0;
      channel   <= chan_left;
      sample_hi <= '0;
      shifter   <= '0;
      audio_dac <= 1'b0;
    end
    else if (bclk_fall)
    begin
      audio_dac <= shifter[SAMPLE_W-1];
      slot_cnt  <= slot_cnt + 1'b1;
      if (slot_cnt == SLOT_LAST)
      begin
        channel <= (channel == chan_left) ? chan_right : chan_left;
        if (channel == chan_right)
        begin
          // new frame, capture buzzers now
          sample_hi <= mix[SAMPLE_W-1 -: ACTIVE_BITS];
          shifter   <= {mix[SAMPLE_W-1 -: ACTIVE_BITS], {(SAMPLE_W-ACTIVE_BITS){1'b0}}};
        end
        else
        begin
          // right slot repeats the frame's sample
          shifter <= {sample_hi, {(SAMPLE_W-ACTIVE_BITS){1'b0}}};
        end
      end
      else if (slot_cnt < CNT_W'(ACTIVE_BITS))
      begin
        // zeros fill in behind, rest of slot is silent
        shifter <= {shifter[SAMPLE_W-2:0], 1'b0};
      end
    end
  end

  assign audio_lrck = (channel == chan_right);

endmodule

`default_nettype wire

/* hw/i2s_mclk_gen.sv */
/*
 * fractional accumulator making the i2s master clock from clk_74a
 * mclk_rise pulses for one cycle as audio_mclk goes high
 */

`default_nettype none

module i2s_mclk_gen #(
  parameter logic [21:0] MCLK_STEP    = arduboy_pkg::MCLK_STEP,
  parameter logic [21:0] MCLK_MODULUS = arduboy_pkg::MCLK_MODULUS
) (
  input  wire  clk_74a,
  input  wire  rst,
  output logic audio_mclk,
  output logic mclk_rise
);

  // stays below modulus plus step, fits in 22 bits
  logic [21:0] accum;

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      accum      <= '0;
      audio_mclk <= 1'b0;
      mclk_rise  <= 1'b0;
    end
    else
    begin
      mclk_rise <= 1'b0;
      if (accum >= MCLK_MODULUS)
      begin
        // wrap and still add this cycle's step
        accum      <= accum - MCLK_MODULUS + MCLK_STEP;
        audio_mclk <= ~audio_mclk;
        // low to high toggles only
        mclk_rise  <= ~audio_mclk;
      end
      else
      begin
        accum <= accum + MCLK_STEP;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/video_cleanup.sv */
/*
 * brings the core's display timing into clk_74a and reshapes it for the
 * scaler: one-cycle syncs, enable from the blanks, rgb zero outside it
 */

`default_nettype none

module video_cleanup #(
  parameter int SYNC_STAGES = 3
) (
  input  wire                  clk_74a,
  input  wire                  rst,
  display_if.video             disp,
  output arduboy_pkg::rgb_t    video_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs
);

  import arduboy_pkg::*;

  // hsync, vsync, hblank, vblank, pixel
  logic [4:0] disp_raw;
  logic [4:0] sync_q [SYNC_STAGES];

  logic hs_s;
  logic vs_s;
  logic hb_s;
  logic vb_s;
  logic pix_s;
  logic hs_prev;
  logic vs_prev;
  logic de_next;

  assign disp_raw = {disp.hsync, disp.vsync, disp.hblank, disp.vblank, disp.pixel};

  ////////////////////////////////////////////////////////////////////
  // synchronizer chain, all five bits side by side

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      sync_q <= '{default: '0};
    end
    else
    begin
      sync_q[0] <= disp_raw;
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign {hs_s, vs_s, hb_s, vb_s, pix_s} = sync_q[SYNC_STAGES-1];

  // active area only when neither blank is set
  assign de_next = ~(hb_s | vb_s);

  ////////////////////////////////////////////////////////////////////
  // output stage

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= '0;
    end
    else
    begin
      hs_prev  <= hs_s;
      vs_prev  <= vs_s;
      // rising edge only, scaler wants a single clock
      video_hs <= hs_s & ~hs_prev;
      video_vs <= vs_s & ~vs_prev;
      video_de <= de_next;
      // rgb must be 0 whenever de is low
      video_rgb <= (de_next && pix_s) ? RGB_WHITE : '0;
    end
  end

endmodule

`default_nettype wire

/* hw/program_rom.sv */
/*
 * core program memory, one 16-bit word per address
 * written by the loader, read by the core with one cycle latency
 */

`default_nettype none

module program_rom (
  input  wire                         clk_74a,
  input  wire                         rom_wr_en,
  input  wire arduboy_pkg::rom_addr_t rom_wr_addr,
  input  wire arduboy_pkg::rom_word_t rom_wr_data,
  input  wire arduboy_pkg::rom_addr_t pgm_addr,
  output arduboy_pkg::rom_word_t      pgm_data
);

  import arduboy_pkg::*;

  // inferred block ram, full 14-bit address space
  rom_word_t mem [2**ROM_ADDR_W];

  // write port from the loader
  always_ff @(posedge clk_74a)
  begin
    if (rom_wr_en)
    begin
      mem[rom_wr_addr] <= rom_wr_data;
    end
  end

  // registered fetch
  always_ff @(posedge clk_74a)
  begin
    pgm_data <= mem[pgm_addr];
  end

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
/*
 * turns 32-bit bridge writes in the rom window into two 16-bit word
 * writes, upper half first; host spaces writes two or more cycles apart
 */

`default_nettype none

module rom_loader (
  input  wire                       clk_74a,
  input  wire                       rst,
  input  wire arduboy_pkg::bridge_word_t bridge_addr,
  input  wire                       bridge_wr,
  input  wire arduboy_pkg::bridge_word_t bridge_wr_data,
  output logic                      rom_wr_en,
  output arduboy_pkg::rom_addr_t    rom_wr_addr,
  output arduboy_pkg::rom_word_t    rom_wr_data
);

  import arduboy_pkg::*;

  loader_state_e state;

  // lower half waits here for the second cycle
  rom_word_t low_data;
  rom_addr_t low_addr;

  // byte window decode
  logic in_window;
  assign in_window = bridge_addr < ROM_WINDOW_BYTES;

  ////////////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      state     <= load_idle;
      rom_wr_en <= 1'b0;
    end
    else
    begin
      rom_wr_en <= 1'b0;
      case (state)
        load_idle:
        begin
          if (bridge_wr && in_window)
          begin
            rom_wr_en <= 1'b1;
            state     <= load_low_half;
          end
        end
        load_low_half:
        begin
          // strobes landing here are lost
          rom_wr_en <= 1'b1;
          state     <= load_idle;
        end
        default:
        begin
          state <= load_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // address and data

  always_ff @(posedge clk_74a)
  begin
    if (state == load_idle)
    begin
      // byte address over two gives the word, big-endian upper half
      rom_wr_addr <= bridge_addr[ROM_ADDR_W:1];
      rom_wr_data <= bridge_wr_data[31:16];
      low_addr    <= bridge_addr[ROM_ADDR_W:1] + 1'b1;
      low_data    <= bridge_wr_data[15:0];
    end
    else
    begin
      rom_wr_addr <= low_addr;
      rom_wr_data <= low_data;
    end
  end

endmodule

`default_nettype wire

/* hw/display_if.sv */
/*
 * display timing group from the core's oled-to-vga stage
 * core side drives, the video cleanup stage receives
 */

`default_nettype none

interface display_if;

  // raw timing, not yet in the clk_74a domain
  logic hsync;
  logic vsync;
  logic hblank;
  logic vblank;
  // monochrome pixel, 1 is lit
  logic pixel;

  modport core (output hsync, output vsync, output hblank, output vblank, output pixel);

  modport video (input hsync, input vsync, input hblank, input vblank, input pixel);

endinterface

`default_nettype wire

/* hw/arduboy_pkg.sv */
/*
 * shared widths, rom geometry, audio constants and state enums
 * for the arduboy console shell; imported by the shell modules
 */

`default_nettype none

package arduboy_pkg;

  ////////////////////////////////////////////////////////////////////
  // bridge and program memory

  // one bridge address or data beat
  typedef logic [31:0] bridge_word_t;

  // core program word, big-endian pair of bytes
  typedef logic [15:0] rom_word_t;

  localparam int ROM_ADDR_W = 14;
  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

  // bridge byte window mapped onto the rom, 16k words
  localparam bridge_word_t ROM_WINDOW_BYTES = 32'd32768;

  ////////////////////////////////////////////////////////////////////
  // video, buttons and audio

  typedef logic [23:0] rgb_t;
  localparam rgb_t RGB_WHITE = 24'hffffff;

  // right, left, down, up, a, b
  localparam int BUTTON_COUNT = 6;

  // 12.288 MHz mclk from 74.25 MHz, two toggles per period
  localparam logic [21:0] MCLK_STEP    = 22'd245760;
  localparam logic [21:0] MCLK_MODULUS = 22'd742500;

  localparam int SAMPLE_W    = 32;
  localparam int ACTIVE_BITS = 16;

  typedef enum logic {load_idle, load_low_half} loader_state_e;
  typedef enum logic {chan_left, chan_right} i2s_channel_e;

endpackage

`default_nettype wire
